// ==== Makefile ====
# Verilator build for the execution unit testbench

VERILATOR ?= verilator
TOP       ?= exec_unit_tb
RTL_TOP   ?= exec_unit
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
+incdir+include
src/alu_pkg.sv
src/alu.sv
src/reg_file.sv
src/exec_ctrl.sv
src/exec_unit.sv
sim/exec_unit_assertions.sv
sim/exec_unit_tb.sv

// ==== include/alu_defs.svh ====
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Data word
`define ALU_WIDTH 16

// Register file size and index width
`define REG_COUNT 16
`define REG_ADDR_W 4

// Opcode field
`define OPCODE_W 4

// Q2.14 fixed point, FMUL keeps product bits FMUL_FRAC+15 down to FMUL_FRAC
`define FMUL_FRAC 14

`endif

// ==== sim/exec_unit_assertions.sv ====
`timescale 1ns/1ps

module exec_unit_assertions
(
	input logic clk,
	input logic rst,
	input logic issue,
	input logic done,
	input logic low,
	input logic negative,
	input logic zero
);

	//////////////////////////////////////////////////
	// Issue to done timing
	//////////////////////////////////////////////////

	// Two cycles from issue to the done pulse
	doneAfterIssue: assert property (@(posedge clk) disable iff (rst)
		issue |-> ##2 done)
	else $error("done did not follow issue after two cycles");

	noStrayDone: assert property (@(posedge clk) disable iff (rst)
		done |-> $past(issue, 2))
	else $error("done without a matching issue");

	// Outputs cleared in the first cycle out of reset
	cleanAfterReset: assert property (@(posedge clk)
		($past(rst) && !rst) |-> (!done && !low && !negative && !zero))
	else $error("done or flags set right after reset");

endmodule

bind exec_unit exec_unit_assertions assertions_i
(
	.clk(clk),
	.rst(rst),
	.issue(issue),
	.done(done),
	.low(low),
	.negative(negative),
	.zero(zero)
);

// ==== sim/exec_unit_tb.sv ====
`timescale 1ns/1ps

module exec_unit_tb;

	import alu_pkg::*;

	typedef struct
	{
		opcode_e op;
		regAddr_t sa;
		regAddr_t sb;
		regAddr_t dst;
		word_t preA;
		word_t preB;
		word_t c;
		word_t d;
		logic l;
		logic n;
		logic z;
	} row_t;

	typedef struct
	{
		int cyc;
		word_t c;
		word_t d;
		logic l;
		logic n;
		logic z;
	} expect_t;

	logic clk;
	logic rst;
	logic issue;
	opcode_e opcode;
	regAddr_t srcA;
	regAddr_t srcB;
	regAddr_t dest;
	logic loadEn;
	regAddr_t loadAddr;
	word_t loadData;
	regAddr_t readAddr;
	word_t readData;
	logic done;
	word_t result;
	word_t resultHi;
	logic low;
	logic negative;
	logic zero;

	row_t dirTable[$];
	expect_t pending[$];
	word_t mirror [16];
	int cycleCount;

	exec_unit dut_i
	(
		.clk(clk), .rst(rst), .issue(issue), .opcode(opcode),
		.srcA(srcA), .srcB(srcB), .dest(dest),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.readAddr(readAddr), .readData(readData),
		.done(done), .result(result), .resultHi(resultHi),
		.low(low), .negative(negative), .zero(zero)
	);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////
	// Reporting and compares
	//////////////////////////////////////////////////

	task automatic failNow(string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopping on first error");
	endtask

	task automatic checkWord(string name, word_t expVal, word_t actVal);
		if (expVal !== actVal)
			failNow($sformatf("mismatch at %0t: %s expected %h got %h",
				$time, name, expVal, actVal));
	endtask

	task automatic checkFlag(string name, logic expVal, logic actVal);
		if (expVal !== actVal)
			failNow($sformatf("mismatch at %0t: %s expected %b got %b",
				$time, name, expVal, actVal));
	endtask

	task automatic checkOp(string name, opcode_e expVal, opcode_e actVal);
		if (expVal !== actVal)
			failNow($sformatf("mismatch at %0t: %s expected %0d got %0d",
				$time, name, expVal, actVal));
	endtask

	//////////////////////////////////////////////////
	// Reference model of the ALU rule table
	//////////////////////////////////////////////////

	function automatic void modelAlu(input opcode_e op, input word_t a, input word_t b,
		output word_t c, output word_t d, output logic l, output logic n, output logic z);
		logic [31:0] p;
		p = {{16{a[15]}}, a} * {{16{b[15]}}, b};
		c = 16'd0;
		d = 16'd0;
		l = 1'b0;
		n = 1'b0;
		z = 1'b0;
		case (op)
			ADD, SUB, AND, OR, XOR:
			begin
				if (op == ADD) c = a + b;
				else if (op == SUB) c = b - a;
				else if (op == AND) c = a & b;
				else if (op == OR) c = a | b;
				else c = a ^ b;
				l = (op == ADD || op == SUB) ? ($signed(a) < $signed(b)) : (a < b);
				n = c[15];
				z = (op == SUB) ? (a == b) : (c == 16'd0);
			end
			CMP:
			begin
				l = a < b;
				n = $signed(a) < $signed(b);
				z = a == b;
			end
			CMPR:
			begin
				l = b < a;
				n = $signed(b) < $signed(a);
				z = a == b;
			end
			NOT:
			begin
				c = ~a;
				l = c < a;
				n = c[15];
				z = c == 16'd0;
			end
			default:
			begin
				// Shifts and multiplies only report Zero
				if (op == LSH) c = (a >= 16'd16) ? 16'd0 : (b << a[3:0]);
				else if (op == RSH) c = (a >= 16'd16) ? 16'd0 : (b >> a[3:0]);
				else if (op == ARSH) c = word_t'({{16{b[15]}}, b} >> a[3:0]);
				else if (op == MUL) c = p[15:0];
				else if (op == FMUL) c = p[29:14];
				if (op == MUL) d = p[31:16];
				z = (op <= FMUL) && (c == 16'd0);
			end
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Bus tasks
	//////////////////////////////////////////////////

	// One clock, then check any completion
	task automatic tick();
		expect_t e;
		@(posedge clk);
		@(negedge clk);
		cycleCount++;
		if (done)
		begin
			if (pending.size() == 0)
				failNow("done was raised with no instruction in flight");
			e = pending.pop_front();
			if (cycleCount - e.cyc != 2)
				failNow($sformatf("done came %0d cycles after issue, not 2",
					cycleCount - e.cyc));
			checkWord("result", e.c, result);
			checkWord("resultHi", e.d, resultHi);
			checkFlag("low", e.l, low);
			checkFlag("negative", e.n, negative);
			checkFlag("zero", e.z, zero);
		end
		else if (pending.size() > 0 && cycleCount - pending[0].cyc >= 2)
			failNow("done did not come 2 cycles after issue");
	endtask

	task automatic drain();
		for (int t = 0; t < 20 && pending.size() > 0; t++)
			tick();
		if (pending.size() > 0)
			failNow("timeout while waiting for done");
	endtask

	task automatic loadReg(regAddr_t addr, word_t data);
		loadEn = 1'b1;
		loadAddr = addr;
		loadData = data;
		mirror[addr] = data;
		tick();
		loadEn = 1'b0;
	endtask

	// Read port settles, then back to the falling edge
	task automatic checkReg(regAddr_t addr);
		readAddr = addr;
		#1;
		checkWord($sformatf("reg[%0d]", addr), mirror[addr], readData);
		tick();
	endtask

	task automatic sendInstr(opcode_e op, regAddr_t sa, regAddr_t sb, regAddr_t dst,
		word_t c, word_t d, logic l, logic n, logic z);
		expect_t e;
		regAddr_t hiAddr;
		hiAddr = dst + 4'd1;
		issue = 1'b1;
		opcode = op;
		srcA = sa;
		srcB = sb;
		dest = dst;
		e = '{cycleCount, c, d, l, n, z};
		pending.push_back(e);
		// Writeback rule
		if (op <= FMUL && op != CMP && op != CMPR)
			mirror[dst] = c;
		if (op == MUL)
			mirror[hiAddr] = d;
		tick();
		issue = 1'b0;
		checkOp("stageOp", op, dut_i.stageOp);
	endtask

	task automatic sendModeled(opcode_e op, regAddr_t sa, regAddr_t sb, regAddr_t dst);
		word_t c;
		word_t d;
		logic l;
		logic n;
		logic z;
		modelAlu(op, mirror[sa], mirror[sb], c, d, l, n, z);
		sendInstr(op, sa, sb, dst, c, d, l, n, z);
	endtask

	task automatic addRow(opcode_e op, regAddr_t dst, word_t a, word_t b,
		word_t c, word_t d, logic l, logic n, logic z);
		dirTable.push_back('{op, 4'd1, 4'd2, dst, a, b, c, d, l, n, z});
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		row_t r;
		int idle;
		void'($urandom(32'hb52ecfb8));
		clk = 1'b0;
		rst = 1'b1;
		issue = 1'b0;
		opcode = ADD;
		srcA = '0;
		srcB = '0;
		dest = '0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		readAddr = '0;
		cycleCount = 0;
		for (int i = 0; i < 16; i++)
			mirror[i] = 16'd0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Reset state
		checkFlag("done", 1'b0, done);
		checkWord("result", 16'd0, result);
		checkWord("resultHi", 16'd0, resultHi);
		checkFlag("low", 1'b0, low);
		checkFlag("negative", 1'b0, negative);
		checkFlag("zero", 1'b0, zero);
		for (int i = 0; i < 16; i++)
			checkReg(regAddr_t'(i));

		// op, dest, A, B, C, D, low, negative, zero
		addRow(ADD, 4'd3, 16'h7FFF, 16'h0001, 16'h8000, 16'h0, 0, 1, 0);
		addRow(ADD, 4'd3, 16'hFFFF, 16'h0001, 16'h0000, 16'h0, 1, 0, 1);
		addRow(SUB, 4'd3, 16'h0001, 16'h8000, 16'h7FFF, 16'h0, 0, 0, 0);
		addRow(SUB, 4'd3, 16'h8000, 16'h8000, 16'h0000, 16'h0, 0, 0, 1);
		addRow(CMP, 4'd3, 16'h8000, 16'h0001, 16'h0000, 16'h0, 0, 1, 0);
		addRow(CMPR, 4'd3, 16'h8000, 16'h0001, 16'h0000, 16'h0, 1, 0, 0);
		addRow(AND, 4'd3, 16'hFFFF, 16'h8000, 16'h8000, 16'h0, 0, 1, 0);
		addRow(OR, 4'd3, 16'h0000, 16'h0000, 16'h0000, 16'h0, 0, 0, 1);
		addRow(XOR, 4'd3, 16'hFFFF, 16'h8000, 16'h7FFF, 16'h0, 0, 0, 0);
		addRow(NOT, 4'd3, 16'h0000, 16'h0000, 16'hFFFF, 16'h0, 0, 1, 0);
		addRow(NOT, 4'd3, 16'hFFFF, 16'h0000, 16'h0000, 16'h0, 1, 0, 1);
		addRow(LSH, 4'd3, 16'd15, 16'h0001, 16'h8000, 16'h0, 0, 0, 0);
		addRow(LSH, 4'd3, 16'd16, 16'hFFFF, 16'h0000, 16'h0, 0, 0, 1);
		addRow(RSH, 4'd3, 16'd15, 16'h8000, 16'h0001, 16'h0, 0, 0, 0);
		addRow(RSH, 4'd3, 16'd16, 16'hFFFF, 16'h0000, 16'h0, 0, 0, 1);
		addRow(ARSH, 4'd3, 16'd15, 16'h8000, 16'hFFFF, 16'h0, 0, 0, 0);
		addRow(ARSH, 4'd3, 16'd16, 16'h8000, 16'h8000, 16'h0, 0, 0, 0);
		addRow(MUL, 4'd3, 16'hFFFF, 16'h8000, 16'h8000, 16'h0000, 0, 0, 0);
		addRow(MUL, 4'd3, 16'h7FFF, 16'h7FFF, 16'h0001, 16'h3FFF, 0, 0, 0);
		// High word wraps into register 0
		addRow(MUL, 4'd15, 16'h8000, 16'h8000, 16'h0000, 16'h4000, 0, 0, 1);
		addRow(FMUL, 4'd3, 16'h4000, 16'h4000, 16'h4000, 16'h0, 0, 0, 0);
		addRow(FMUL, 4'd3, 16'h8000, 16'h4000, 16'h8000, 16'h0, 0, 0, 0);
		addRow(opcode_e'(4'd13), 4'd3, 16'h1234, 16'h5678, 16'h0, 16'h0, 0, 0, 0);
		addRow(opcode_e'(4'd15), 4'd3, 16'hFFFF, 16'hFFFF, 16'h0, 16'h0, 0, 0, 0);

		foreach (dirTable[i])
		begin
			r = dirTable[i];
			loadReg(r.dst + 4'd1, 16'h5A5A);
			loadReg(r.dst, 16'hA5A5);
			loadReg(r.sa, r.preA);
			loadReg(r.sb, r.preB);
			sendInstr(r.op, r.sa, r.sb, r.dst, r.c, r.d, r.l, r.n, r.z);
			drain();
			checkReg(r.dst);
			checkReg(r.dst + 4'd1);
		end

		// Dependent instructions back to back
		loadReg(4'd1, 16'h0003);
		loadReg(4'd2, 16'h0005);
		sendModeled(ADD, 4'd1, 4'd2, 4'd4);
		sendModeled(SUB, 4'd4, 4'd2, 4'd5);
		sendModeled(MUL, 4'd5, 4'd4, 4'd6);
		sendModeled(ADD, 4'd7, 4'd6, 4'd8);
		sendModeled(MUL, 4'd8, 4'd8, 4'd15);
		sendModeled(XOR, 4'd0, 4'd15, 4'd9);
		drain();
		for (int i = 0; i < 16; i++)
			checkReg(regAddr_t'(i));

		// Random stream
		for (int i = 0; i < 16; i++)
			loadReg(regAddr_t'(i), 16'($urandom));
		for (int i = 0; i < 200; i++)
		begin
			idle = $urandom % 4;
			repeat (idle) tick();
			sendModeled(opcode_e'(4'($urandom)), 4'($urandom), 4'($urandom), 4'($urandom));
		end
		drain();
		for (int i = 0; i < 16; i++)
			checkReg(regAddr_t'(i));

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu
(
	input  logic [`ALU_WIDTH-1:0] a,
	input  logic [`ALU_WIDTH-1:0] b,
	input  logic [`OPCODE_W-1:0] op,
	output logic [`ALU_WIDTH-1:0] c,
	output logic [`ALU_WIDTH-1:0] d,
	output logic low,
	output logic negative,
	output logic zero
);

	import alu_pkg::*;

	// Full signed product, shared by MUL and FMUL
	logic signed [2*`ALU_WIDTH-1:0] product;

	assign product = $signed(a) * $signed(b);

	//////////////////////////////////////////////////
	// Operation select
	//////////////////////////////////////////////////

	always_comb
	begin
		c = '0;
		d = '0;
		low = 1'b0;
		negative = 1'b0;
		zero = 1'b0;
		case (opcode_e'(op))
			ADD:
			begin
				c = a + b;
				low = $signed(a) < $signed(b);
				negative = c[`ALU_WIDTH-1];
				zero = (c == '0);
			end
			SUB:
			begin
				c = b - a;
				low = $signed(a) < $signed(b);
				negative = c[`ALU_WIDTH-1];
				zero = (a == b);
			end
			// Compares leave C and D at zero
			CMP:
			begin
				low = a < b;
				negative = $signed(a) < $signed(b);
				zero = (a == b);
			end
			CMPR:
			begin
				low = b < a;
				negative = $signed(b) < $signed(a);
				zero = (a == b);
			end
			AND:
			begin
				c = a & b;
				low = a < b;
				negative = c[`ALU_WIDTH-1];
				zero = (c == '0);
			end
			OR:
			begin
				c = a | b;
				low = a < b;
				negative = c[`ALU_WIDTH-1];
				zero = (c == '0);
			end
			XOR:
			begin
				c = a ^ b;
				low = a < b;
				negative = c[`ALU_WIDTH-1];
				zero = (c == '0);
			end
			NOT:
			begin
				c = ~a;
				low = c < a;
				negative = c[`ALU_WIDTH-1];
				zero = (c == '0);
			end
			// Full-width amounts, 16 and up shift everything out
			LSH:
			begin
				c = b << a;
				zero = (c == '0);
			end
			RSH:
			begin
				c = b >> a;
				zero = (c == '0);
			end
			ARSH:
			begin
				c = $signed(b) >>> a[3:0];
				zero = (c == '0);
			end
			MUL:
			begin
				c = product[`ALU_WIDTH-1:0];
				d = product[2*`ALU_WIDTH-1:`ALU_WIDTH];
				zero = (c == '0);
			end
			FMUL:
			begin
				c = product[`FMUL_FRAC+`ALU_WIDTH-1:`FMUL_FRAC];
				zero = (c == '0);
			end
			default:
			begin
				c = '0;
				zero = 1'b0;
			end
		endcase
	end

endmodule

// ==== src/alu_pkg.sv ====
`include "alu_defs.svh"

package alu_pkg;

	//////////////////////////////////////////////////
	// Datapath types
	//////////////////////////////////////////////////

	typedef logic [`ALU_WIDTH-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] regAddr_t;

	// Codes 13 to 15 are left undefined
	typedef enum logic [`OPCODE_W-1:0]
	{
		ADD  = 4'd0,
		SUB  = 4'd1,
		CMP  = 4'd2,
		CMPR = 4'd3,
		AND  = 4'd4,
		OR   = 4'd5,
		XOR  = 4'd6,
		NOT  = 4'd7,
		LSH  = 4'd8,
		RSH  = 4'd9,
		ARSH = 4'd10,
		MUL  = 4'd11,
		FMUL = 4'd12
	} opcode_e;

endpackage

// ==== src/exec_ctrl.sv ====
`timescale 1ns/1ps

module exec_ctrl
(
	input  logic clk,
	input  logic rst,
	input  logic issue,
	input  alu_pkg::opcode_e opcode,
	input  alu_pkg::regAddr_t srcA,
	input  alu_pkg::regAddr_t srcB,
	input  alu_pkg::regAddr_t dest,
	input  alu_pkg::word_t rdDataA,
	input  alu_pkg::word_t rdDataB,
	output alu_pkg::word_t opA,
	output alu_pkg::word_t opB,
	output alu_pkg::opcode_e stageOp,
	input  alu_pkg::word_t aluC,
	input  alu_pkg::word_t aluD,
	input  logic aluLow,
	input  logic aluNeg,
	input  logic aluZero,
	output logic wbEn,
	output logic wbHiEn,
	output alu_pkg::regAddr_t wbAddr,
	output alu_pkg::regAddr_t wbHiAddr,
	output alu_pkg::word_t wbData,
	output alu_pkg::word_t wbHiData,
	output logic done,
	output alu_pkg::word_t result,
	output alu_pkg::word_t resultHi,
	output logic low,
	output logic negative,
	output logic zero
);

	import alu_pkg::*;

	logic stageValid;
	regAddr_t stageDest;

	// Value this source sees, including the write at this edge
	function automatic word_t bypass(regAddr_t addr, word_t regData);
		word_t val;
		val = regData;
		if (wbEn && wbAddr == addr)
			val = wbData;
		// High word last so it wins
		if (wbHiEn && wbHiAddr == addr)
			val = wbHiData;
		return val;
	endfunction

	//////////////////////////////////////////////////
	// Operand stage
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			stageValid <= 1'b0;
			stageOp <= ADD;
			stageDest <= '0;
			opA <= '0;
			opB <= '0;
		end
		else
		begin
			stageValid <= issue;
			if (issue)
			begin
				stageOp <= opcode;
				stageDest <= dest;
				opA <= bypass(srcA, rdDataA);
				opB <= bypass(srcB, rdDataB);
			end
		end
	end

	//////////////////////////////////////////////////
	// Writeback decode
	//////////////////////////////////////////////////

	always_comb
	begin
		case (stageOp)
			ADD, SUB, AND, OR, XOR, NOT, LSH, RSH, ARSH, MUL, FMUL:
				wbEn = stageValid;
			default:
				wbEn = 1'b0;
		endcase
	end

	assign wbHiEn = stageValid && (stageOp == MUL);
	assign wbAddr = stageDest;
	// Wraps from 15 back to 0
	assign wbHiAddr = stageDest + 1'b1;
	assign wbData = aluC;
	assign wbHiData = aluD;

	// Result stage
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			done <= 1'b0;
			result <= '0;
			resultHi <= '0;
			low <= 1'b0;
			negative <= 1'b0;
			zero <= 1'b0;
		end
		else
		begin
			done <= stageValid;
			if (stageValid)
			begin
				result <= aluC;
				resultHi <= aluD;
				low <= aluLow;
				negative <= aluNeg;
				zero <= aluZero;
			end
		end
	end

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit
(
	input  logic clk,
	input  logic rst,
	input  logic issue,
	input  alu_pkg::opcode_e opcode,
	input  alu_pkg::regAddr_t srcA,
	input  alu_pkg::regAddr_t srcB,
	input  alu_pkg::regAddr_t dest,
	input  logic loadEn,
	input  alu_pkg::regAddr_t loadAddr,
	input  alu_pkg::word_t loadData,
	input  alu_pkg::regAddr_t readAddr,
	output alu_pkg::word_t readData,
	output logic done,
	output alu_pkg::word_t result,
	output alu_pkg::word_t resultHi,
	output logic low,
	output logic negative,
	output logic zero
);

	import alu_pkg::*;

	// Operand path
	word_t rdDataA;
	word_t rdDataB;
	word_t opA;
	word_t opB;
	opcode_e stageOp;

	// ALU back to control
	word_t aluC;
	word_t aluD;
	logic aluLow;
	logic aluNeg;
	logic aluZero;

	// Writeback into the register file
	logic wbEn;
	logic wbHiEn;
	regAddr_t wbAddr;
	regAddr_t wbHiAddr;
	word_t wbData;
	word_t wbHiData;

	reg_file regFile_i
	(
		.clk(clk),
		.rst(rst),
		.rdAddrA(srcA),
		.rdAddrB(srcB),
		.readAddr(readAddr),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.readData(readData),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.wbEn(wbEn),
		.wbHiEn(wbHiEn),
		.wbAddr(wbAddr),
		.wbHiAddr(wbHiAddr),
		.wbData(wbData),
		.wbHiData(wbHiData)
	);

	exec_ctrl execCtrl_i
	(
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.opcode(opcode),
		.srcA(srcA),
		.srcB(srcB),
		.dest(dest),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.opA(opA),
		.opB(opB),
		.stageOp(stageOp),
		.aluC(aluC),
		.aluD(aluD),
		.aluLow(aluLow),
		.aluNeg(aluNeg),
		.aluZero(aluZero),
		.wbEn(wbEn),
		.wbHiEn(wbHiEn),
		.wbAddr(wbAddr),
		.wbHiAddr(wbHiAddr),
		.wbData(wbData),
		.wbHiData(wbHiData),
		.done(done),
		.result(result),
		.resultHi(resultHi),
		.low(low),
		.negative(negative),
		.zero(zero)
	);

	alu alu_i
	(
		.a(opA),
		.b(opB),
		.op(stageOp),
		.c(aluC),
		.d(aluD),
		.low(aluLow),
		.negative(aluNeg),
		.zero(aluZero)
	);

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`include "alu_defs.svh"

module reg_file
(
	input  logic clk,
	input  logic rst,
	input  logic [`REG_ADDR_W-1:0] rdAddrA,
	input  logic [`REG_ADDR_W-1:0] rdAddrB,
	input  logic [`REG_ADDR_W-1:0] readAddr,
	output logic [`ALU_WIDTH-1:0] rdDataA,
	output logic [`ALU_WIDTH-1:0] rdDataB,
	output logic [`ALU_WIDTH-1:0] readData,
	input  logic loadEn,
	input  logic [`REG_ADDR_W-1:0] loadAddr,
	input  logic [`ALU_WIDTH-1:0] loadData,
	input  logic wbEn,
	input  logic wbHiEn,
	input  logic [`REG_ADDR_W-1:0] wbAddr,
	input  logic [`REG_ADDR_W-1:0] wbHiAddr,
	input  logic [`ALU_WIDTH-1:0] wbData,
	input  logic [`ALU_WIDTH-1:0] wbHiData
);

	import alu_pkg::*;

	word_t regs [`REG_COUNT];

	//////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////

	// Later assignments win, so high result beats low result beats load
	always_ff @(posedge clk)
	begin
		if (rst)
			regs <= '{default: '0};
		else
		begin
			if (loadEn)
				regs[loadAddr] <= loadData;
			if (wbEn)
				regs[wbAddr] <= wbData;
			if (wbHiEn)
				regs[wbHiAddr] <= wbHiData;
		end
	end

	// Asynchronous reads
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];
	assign readData = regs[readAddr];

endmodule
